// File: rtl/sv32_config.svh
`ifndef SV32_CONFIG_SVH
`define SV32_CONFIG_SVH

// number of page walkers, at least 2
`define SV32_NUM_WALKERS 4

// request tag width
`define SV32_TAG_W 4

`endif

// File: rtl/sv32_pkg.sv
`default_nettype none

package sv32_pkg;

    `include "sv32_config.svh"

    localparam int unsigned WALK_IDX_W = $clog2(`SV32_NUM_WALKERS);

    typedef logic [`SV32_NUM_WALKERS-1:0] walk_vec_t;
    typedef logic [WALK_IDX_W-1:0]        walk_idx_t;

    typedef enum logic [1:0] {
        ACC_LOAD  = 2'd0,
        ACC_STORE = 2'd1,
        ACC_FETCH = 2'd2
    } access_kind_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef enum logic [2:0] {
        XF_NONE,
        XF_INVALID,
        XF_PERM,
        XF_PRIV,
        XF_MISALIGNED
    } xlat_fault_e;

    typedef enum logic [2:0] {
        W_IDLE,
        W_READ1,
        W_CHECK1,
        W_READ0,
        W_CHECK0,
        W_DONE
    } walk_state_e;

    // satp bit 31 is the mode, bits 21:0 the root ppn
    typedef struct packed {
        logic [31:0]            vaddr;
        logic [31:0]            satp;
        priv_e                  priv;
        logic                   sum;
        access_kind_e           access;
        logic [`SV32_TAG_W-1:0] tag;
    } xlat_req_t;

    typedef struct packed {
        logic [`SV32_TAG_W-1:0] tag;
        logic [33:0]            paddr;
        xlat_fault_e            fault;
    } xlat_resp_t;

    // sv32 page table entry layout
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } sv32_pte_t;

    // first requester after last, last itself has lowest priority
    function automatic walk_idx_t rr_pick(walk_vec_t reqs, walk_idx_t last);
        walk_idx_t pick;
        int        idx;
        pick = last;
        for (int k = `SV32_NUM_WALKERS; k >= 1; k--) begin
            idx = (int'(last) + k) % `SV32_NUM_WALKERS;
            if (reqs[idx]) begin
                pick = walk_idx_t'(idx);
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

// File: rtl/walk_dispatch.sv
`default_nettype none

`include "sv32_config.svh"

module walk_dispatch
    import sv32_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         req_valid,
    input  xlat_req_t                    req,
    input  logic [`SV32_NUM_WALKERS-1:0] free,
    output logic [`SV32_NUM_WALKERS-1:0] start,
    output xlat_req_t                    start_req,
    output logic                         busy
);

    logic [`SV32_NUM_WALKERS-1:0] avail;
    logic [`SV32_NUM_WALKERS-1:0] pick;
    logic [`SV32_NUM_WALKERS-1:0] claimed;

    // a walker being started this cycle still looks free
    assign avail = free & ~start;

    // lowest free walker wins
    always_comb begin
        pick = '0;
        for (int i = `SV32_NUM_WALKERS - 1; i >= 0; i--) begin
            if (avail[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign claimed = req_valid ? pick : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= '0;
            busy  <= 1'b0;
        end else if (flush) begin
            // every walker is idle after a flush
            start <= '0;
            busy  <= 1'b0;
        end else begin
            start <= claimed;
            busy  <= ~|(avail & ~claimed);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            start_req <= req;
        end
    end

    // requester must hold off while busy
    a_no_req_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> !busy
    );

endmodule

`default_nettype wire

// File: rtl/page_walker.sv
`default_nettype none

module page_walker
    import sv32_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        start,
    input  xlat_req_t   start_req,
    input  logic        rd_done,
    input  logic [31:0] rd_data,
    input  logic        take,
    output logic        free,
    output logic        rd_en,
    output logic [33:0] rd_addr,
    output logic        done,
    output xlat_resp_t  result
);

    walk_state_e state;
    xlat_req_t   req_q;
    sv32_pte_t   pte_q;
    xlat_resp_t  res_q;

    logic        bare;
    logic        leaf_check;
    logic        perm_bad;
    logic        chk_descend;
    xlat_fault_e chk_fault;
    logic [33:0] leaf_paddr;

    // no translation for satp mode 0 or machine mode
    assign bare = !start_req.satp[31] || (start_req.priv == PRIV_M);

    assign free   = (state == W_IDLE);
    assign done   = (state == W_DONE);
    assign rd_en  = (state == W_READ1) || (state == W_READ0);
    assign result = res_q;

    always_comb begin
        if (state == W_READ0) begin
            rd_addr = {pte_q.ppn1, pte_q.ppn0, req_q.vaddr[21:12], 2'b00};
        end else begin
            rd_addr = {req_q.satp[21:0], req_q.vaddr[31:22], 2'b00};
        end
    end

    always_comb begin
        case (req_q.access)
            ACC_FETCH: perm_bad = !pte_q.x;
            ACC_LOAD:  perm_bad = !pte_q.r;
            ACC_STORE: perm_bad = !pte_q.w || !pte_q.d;
            default:   perm_bad = 1'b1;
        endcase
    end

    // pte checks, in priority order
    always_comb begin
        chk_fault   = XF_NONE;
        chk_descend = 1'b0;
        if (!pte_q.v || (!pte_q.r && pte_q.w)) begin
            chk_fault = XF_INVALID;
        end else if (!pte_q.r && !pte_q.w && !pte_q.x) begin
            // pointer to the next level, only legal at level 1
            if (state == W_CHECK1) begin
                chk_descend = 1'b1;
            end else begin
                chk_fault = XF_INVALID;
            end
        end else if ((!pte_q.u && req_q.priv == PRIV_U) ||
                     (pte_q.u && req_q.priv == PRIV_S && !req_q.sum)) begin
            chk_fault = XF_PRIV;
        end else if (perm_bad) begin
            chk_fault = XF_PERM;
        end else if (state == W_CHECK1 && pte_q.ppn0 != 10'd0) begin
            chk_fault = XF_MISALIGNED;
        end
    end

    // superpage keeps vpn0 from the virtual address
    always_comb begin
        if (state == W_CHECK1) begin
            leaf_paddr = {pte_q.ppn1, req_q.vaddr[21:0]};
        end else begin
            leaf_paddr = {pte_q.ppn1, pte_q.ppn0, req_q.vaddr[11:0]};
        end
    end

    assign leaf_check = ((state == W_CHECK1) && !chk_descend) || (state == W_CHECK0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= W_IDLE;
        end else if (flush) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (start) begin
                        state <= bare ? W_DONE : W_READ1;
                    end
                end
                W_READ1: begin
                    if (rd_done) begin
                        state <= W_CHECK1;
                    end
                end
                W_CHECK1: begin
                    state <= chk_descend ? W_READ0 : W_DONE;
                end
                W_READ0: begin
                    if (rd_done) begin
                        state <= W_CHECK0;
                    end
                end
                W_CHECK0: begin
                    state <= W_DONE;
                end
                W_DONE: begin
                    // hold the result until the collector has it
                    if (take) begin
                        state <= W_IDLE;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (free && start) begin
            req_q       <= start_req;
            res_q.tag   <= start_req.tag;
            res_q.paddr <= {2'b00, start_req.vaddr};
            res_q.fault <= XF_NONE;
        end
        if (rd_done) begin
            pte_q <= rd_data;
        end
        if (leaf_check) begin
            res_q.fault <= chk_fault;
            res_q.paddr <= (chk_fault == XF_NONE) ? leaf_paddr : '0;
        end
    end

    a_done_only_when_reading: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_done |-> (state == W_READ1 || state == W_READ0)
    );

    a_start_only_when_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> free
    );

endmodule

`default_nettype wire

// File: rtl/pte_read_arbiter.sv
`default_nettype none

`include "sv32_config.svh"

module pte_read_arbiter
    import sv32_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush,
    input  logic [`SV32_NUM_WALKERS-1:0]       rd_en,
    input  logic [`SV32_NUM_WALKERS-1:0][33:0] rd_addr,
    input  logic                               mem_rd_done,
    input  logic [31:0]                        mem_rd_data,
    output logic [`SV32_NUM_WALKERS-1:0]       rd_done,
    output logic [31:0]                        rd_data,
    output logic                               mem_rd_en,
    output logic [33:0]                        mem_addr
);

    walk_idx_t   gnt_q;
    walk_idx_t   pick;
    logic        busy_q;
    logic        drop_q;
    logic [33:0] addr_q;

    assign pick      = rr_pick(rd_en, gnt_q);
    assign mem_rd_en = busy_q;
    assign mem_addr  = addr_q;
    assign rd_data   = mem_rd_data;

    // a dropped read returns to nobody
    always_comb begin
        rd_done = '0;
        if (busy_q && mem_rd_done && !drop_q) begin
            rd_done[gnt_q] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q  <= '0;
            busy_q <= 1'b0;
            drop_q <= 1'b0;
        end else if (busy_q) begin
            if (mem_rd_done) begin
                busy_q <= 1'b0;
                drop_q <= 1'b0;
            end else if (flush) begin
                // read stays on the bus until the memory answers
                drop_q <= 1'b1;
            end
        end else if (|rd_en && !flush) begin
            busy_q <= 1'b1;
            gnt_q  <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && |rd_en) begin
            addr_q <= rd_addr[pick];
        end
    end

    // memory answers only a read that is on the bus
    a_done_needs_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_rd_done |-> mem_rd_en
    );

    // granted walker keeps asking unless its read was dropped
    a_grant_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_q && !drop_q && !flush |-> rd_en[gnt_q]
    );

endmodule

`default_nettype wire

// File: rtl/result_collect.sv
`default_nettype none

`include "sv32_config.svh"

module result_collect
    import sv32_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush,
    input  logic [`SV32_NUM_WALKERS-1:0]            done,
    input  xlat_resp_t [`SV32_NUM_WALKERS-1:0]      result,
    output logic [`SV32_NUM_WALKERS-1:0]            take,
    output logic                                    resp_valid,
    output xlat_resp_t                              resp
);

    walk_idx_t last_q;
    walk_idx_t sel;
    logic      any;

    assign sel = rr_pick(done, last_q);

    // nothing is taken in a flush cycle, walkers go idle instead
    assign any = |done && !flush;

    always_comb begin
        take = '0;
        if (any) begin
            take[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q     <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= any;
            if (any) begin
                last_q <= sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any) begin
            resp <= result[sel];
        end
    end

    // a taken walker leaves its done state
    a_take_releases: assert property (
        @(posedge clk) disable iff (!rst_n)
        (|take) |=> ((done & $past(take)) == '0)
    );

endmodule

`default_nettype wire

// File: rtl/sv32_mmu.sv
`default_nettype none

`include "sv32_config.svh"

module sv32_mmu
    import sv32_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        req_valid,
    input  xlat_req_t   req,
    output logic        busy,
    output logic        resp_valid,
    output xlat_resp_t  resp,
    output logic        mem_rd_en,
    output logic [33:0] mem_addr,
    input  logic        mem_rd_done,
    input  logic [31:0] mem_rd_data
);

    logic [`SV32_NUM_WALKERS-1:0]       wk_start;
    logic [`SV32_NUM_WALKERS-1:0]       wk_free;
    logic [`SV32_NUM_WALKERS-1:0]       wk_rd_en;
    logic [`SV32_NUM_WALKERS-1:0][33:0] wk_rd_addr;
    logic [`SV32_NUM_WALKERS-1:0]       wk_rd_done;
    logic [`SV32_NUM_WALKERS-1:0]       wk_done;
    logic [`SV32_NUM_WALKERS-1:0]       wk_take;
    xlat_resp_t [`SV32_NUM_WALKERS-1:0] wk_result;
    xlat_req_t                          start_req;
    logic [31:0]                        rd_data;

    walk_dispatch i_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .free      (wk_free),
        .start     (wk_start),
        .start_req (start_req),
        .busy      (busy)
    );

    // one walker per slot, all fed from the same registered request
    for (genvar g = 0; g < `SV32_NUM_WALKERS; g++) begin : g_walker
        page_walker i_walker (
            .clk       (clk),
            .rst_n     (rst_n),
            .flush     (flush),
            .start     (wk_start[g]),
            .start_req (start_req),
            .rd_done   (wk_rd_done[g]),
            .rd_data   (rd_data),
            .take      (wk_take[g]),
            .free      (wk_free[g]),
            .rd_en     (wk_rd_en[g]),
            .rd_addr   (wk_rd_addr[g]),
            .done      (wk_done[g]),
            .result    (wk_result[g])
        );
    end

    pte_read_arbiter i_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .rd_en       (wk_rd_en),
        .rd_addr     (wk_rd_addr),
        .mem_rd_done (mem_rd_done),
        .mem_rd_data (mem_rd_data),
        .rd_done     (wk_rd_done),
        .rd_data     (rd_data),
        .mem_rd_en   (mem_rd_en),
        .mem_addr    (mem_addr)
    );

    result_collect i_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .done       (wk_done),
        .result     (wk_result),
        .take       (wk_take),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

// File: tests/pt_mem_model.sv
`default_nettype none

module pt_mem_model #(
    parameter logic [15:0] SEED = 16'd62692
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_en,
    input  logic [33:0] addr,
    output logic        rd_done,
    output logic [31:0] rd_data
);

    localparam int DEPTH = 4096;

    logic [31:0] words [DEPTH];
    logic [15:0] lfsr_q;
    logic        active;
    logic [1:0]  wait_q;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic write_word(input logic [33:0] a, input logic [31:0] data);
        words[a[13:2]] = data;
    endtask

    // unwritten words never have V set
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = (i * 32'h9E37_79B5 + 32'h0000_6A09) & 32'hFFFF_FFFE;
        end
    end

    always @(posedge clk or negedge rst_n) begin : serve
        logic [15:0] s1;
        logic [15:0] s2;
        if (!rst_n) begin
            lfsr_q  <= SEED;
            active  <= 1'b0;
            wait_q  <= 2'd0;
            rd_done <= 1'b0;
            rd_data <= '0;
        end else begin
            rd_done <= 1'b0;
            if (active) begin
                if (wait_q == 2'd0) begin
                    active  <= 1'b0;
                    rd_done <= 1'b1;
                    rd_data <= words[addr[13:2]];
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end else if (rd_en && !rd_done) begin
                // two lfsr bits give 1 to 4 cycles
                s1 = lfsr_next(lfsr_q);
                s2 = lfsr_next(s1);
                lfsr_q <= s2;
                active <= 1'b1;
                wait_q <= {s1[0], s2[0]};
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_sv32_mmu.sv
`default_nettype none

`include "sv32_config.svh"

module tb_sv32_mmu
    import sv32_pkg::*;
();

    localparam logic [31:0] SATP_SV32 = 32'h8000_0001;
    localparam int          NUM_TAGS  = 1 << `SV32_TAG_W;
    // requests issued over all tests
    localparam int          NUM_REQS  = 31;
    localparam int          WATCHDOG  = NUM_REQS * 200 + 300;

    // V R W X U G A D in bits 0 to 7
    localparam logic [7:0] PTE_PTR  = 8'h01;
    localparam logic [7:0] PTE_FULL = 8'hCF;
    localparam logic [7:0] PTE_USER = 8'hDF;
    localparam logic [7:0] PTE_NO_D = 8'h4F;
    localparam logic [7:0] PTE_NO_X = 8'hC7;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        req_valid;
    xlat_req_t   req;
    logic        busy;
    logic        resp_valid;
    xlat_resp_t  resp;
    logic        mem_rd_en;
    logic [33:0] mem_addr;
    logic        mem_rd_done;
    logic [31:0] mem_rd_data;

    xlat_resp_t  got [NUM_TAGS];
    int          got_cnt [NUM_TAGS];
    int          resp_total;
    xlat_resp_t  last_resp;
    int          rd_starts;
    logic        en_q;
    logic [15:0] lfsr_q;

    sv32_mmu i_sv32_mmu (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .mem_rd_en   (mem_rd_en),
        .mem_addr    (mem_addr),
        .mem_rd_done (mem_rd_done),
        .mem_rd_data (mem_rd_data)
    );

    pt_mem_model i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (mem_rd_en),
        .addr    (mem_addr),
        .rd_done (mem_rd_done),
        .rd_data (mem_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // responses by tag, and page-table reads started
    always @(posedge clk) begin
        if (rst_n && resp_valid) begin
            got[resp.tag] = resp;
            got_cnt[resp.tag]++;
            resp_total++;
            last_resp = resp;
        end
        if (mem_rd_en && !en_q) begin
            rd_starts++;
            // all page tables sit in the first 16 KiB
            assert (mem_addr[33:14] == '0 && mem_addr[1:0] == 2'b00) else begin
                $display("FAIL mem_addr: got %h, expected an aligned word below %h",
                         mem_addr, 34'h4000);
                abort_run();
            end
        end
        en_q = mem_rd_en;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] make_va(input int v1, input int v0, input int off);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = v1;
        b = v0;
        c = off;
        return {a[9:0], b[9:0], c[11:0]};
    endfunction

    function automatic xlat_req_t build_req(input logic [31:0] va, input priv_e pv,
                                            input logic sm, input access_kind_e acc,
                                            input int tag);
        xlat_req_t r;
        r.vaddr  = va;
        r.satp   = SATP_SV32;
        r.priv   = pv;
        r.sum    = sm;
        r.access = acc;
        r.tag    = tag[`SV32_TAG_W-1:0];
        return r;
    endfunction

    // expected translation, walking the model's own word array
    function automatic xlat_resp_t ref_xlat(input xlat_req_t r);
        xlat_resp_t  o;
        logic [33:0] a;
        logic [31:0] pte;
        o.tag   = r.tag;
        o.paddr = {2'b00, r.vaddr};
        o.fault = XF_NONE;
        if (!r.satp[31] || r.priv == PRIV_M) begin
            return o;
        end
        a = {r.satp[21:0], r.vaddr[31:22], 2'b00};
        for (int lvl = 1; lvl >= 0; lvl--) begin
            pte = i_mem.words[a[13:2]];
            if (!pte[0] || (!pte[1] && pte[2])) begin
                o.fault = XF_INVALID;
            end else if (pte[3:1] == 3'b000) begin
                if (lvl == 1) begin
                    a = {pte[31:10], r.vaddr[21:12], 2'b00};
                    continue;
                end
                o.fault = XF_INVALID;
            end else if ((!pte[4] && r.priv == PRIV_U) ||
                         (pte[4] && r.priv == PRIV_S && !r.sum)) begin
                o.fault = XF_PRIV;
            end else if ((r.access == ACC_FETCH && !pte[3]) ||
                         (r.access == ACC_LOAD && !pte[1]) ||
                         (r.access == ACC_STORE && (!pte[2] || !pte[7]))) begin
                o.fault = XF_PERM;
            end else if (lvl == 1 && pte[19:10] != 10'd0) begin
                o.fault = XF_MISALIGNED;
            end
            if (o.fault != XF_NONE) begin
                o.paddr = '0;
            end else if (lvl == 1) begin
                o.paddr = {pte[31:20], r.vaddr[21:0]};
            end else begin
                o.paddr = {pte[31:10], r.vaddr[11:0]};
            end
            return o;
        end
        return o;
    endfunction

    task automatic build_tables();
        // root at ppn 1, level-0 tables at ppn 2 and 3
        i_mem.write_word(34'h1000, make_pte(22'd2, PTE_PTR));
        i_mem.write_word(34'h1004, make_pte({12'h123, 10'd0}, PTE_FULL));
        i_mem.write_word(34'h1008, make_pte({12'h124, 10'd5}, PTE_FULL));
        i_mem.write_word(34'h100C, make_pte(22'd3, PTE_PTR));
        i_mem.write_word(34'h2000, make_pte(22'h0ABCD, PTE_FULL));
        i_mem.write_word(34'h2004, make_pte(22'h0ABCE, PTE_NO_D));
        i_mem.write_word(34'h2008, make_pte(22'h0ABCF, PTE_NO_X));
        i_mem.write_word(34'h200C, make_pte(22'h0ABD0, PTE_USER));
        i_mem.write_word(34'h2010, 32'h0);
        i_mem.write_word(34'h3000, make_pte(22'h3FFFFF, PTE_USER));
        i_mem.write_word(34'h3004, make_pte(22'd2, PTE_PTR));
    endtask

    task automatic clear_seen();
        for (int t = 0; t < NUM_TAGS; t++) begin
            got_cnt[t] = 0;
        end
        resp_total = 0;
    endtask

    // busy seen here already covers the previous request
    task automatic send(input xlat_req_t r);
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic check_resp(input xlat_resp_t act, input xlat_resp_t exp);
        assert (act.paddr == exp.paddr) else begin
            $display("FAIL resp.paddr (tag %h): got %h, expected %h", act.tag,
                     act.paddr, exp.paddr);
            abort_run();
        end
        assert (act.fault == exp.fault) else begin
            $display("FAIL resp.fault (tag %h): got %h, expected %h", act.tag,
                     act.fault, exp.fault);
            abort_run();
        end
    endtask

    task automatic xlat_one(input xlat_req_t r, input xlat_fault_e want, input int reads);
        xlat_resp_t exp;
        int         starts0;
        int         total0;
        exp = ref_xlat(r);
        assert (exp.fault == want) else begin
            $display("page tables give fault %s for tag %0d where %s was intended",
                     exp.fault.name(), r.tag, want.name());
            abort_run();
        end
        starts0 = rd_starts;
        total0  = resp_total;
        send(r);
        while (resp_total == total0) begin
            @(posedge clk);
        end
        assert (last_resp.tag == r.tag) else begin
            $display("FAIL resp.tag: got %h, expected %h", last_resp.tag, r.tag);
            abort_run();
        end
        check_resp(last_resp, exp);
        assert (rd_starts - starts0 == reads) else begin
            $display("FAIL mem_rd_en rises (tag %h): got %h, expected %h", r.tag,
                     rd_starts - starts0, reads);
            abort_run();
        end
    endtask

    task automatic test_bare();
        xlat_req_t r;
        r = build_req(32'hDEAD_BEEF, PRIV_S, 1'b0, ACC_LOAD, 1);
        r.satp = 32'h0000_0001;
        xlat_one(r, XF_NONE, 0);
        xlat_one(build_req(32'h8123_4567, PRIV_M, 1'b0, ACC_STORE, 2), XF_NONE, 0);
    endtask

    task automatic test_walk_4k();
        xlat_one(build_req(make_va(0, 0, 'h345), PRIV_S, 1'b0, ACC_LOAD, 3), XF_NONE, 2);
        xlat_one(build_req(make_va(0, 0, 'h346), PRIV_S, 1'b0, ACC_STORE, 4), XF_NONE, 2);
        xlat_one(build_req(make_va(0, 0, 'h348), PRIV_S, 1'b0, ACC_FETCH, 5), XF_NONE, 2);
        // ppn at the top of the 34-bit space
        xlat_one(build_req(make_va(3, 0, 'hFFC), PRIV_U, 1'b0, ACC_LOAD, 6), XF_NONE, 2);
    endtask

    task automatic test_superpage();
        xlat_one(build_req(make_va(1, 'h2AB, 'h123), PRIV_S, 1'b0, ACC_LOAD, 7), XF_NONE, 1);
        xlat_one(build_req(make_va(2, 1, 0), PRIV_S, 1'b0, ACC_LOAD, 8), XF_MISALIGNED, 1);
    endtask

    task automatic test_faults();
        xlat_one(build_req(make_va(0, 4, 0), PRIV_S, 1'b0, ACC_LOAD, 9), XF_INVALID, 2);
        xlat_one(build_req(make_va(5, 0, 0), PRIV_S, 1'b0, ACC_LOAD, 10), XF_INVALID, 1);
        xlat_one(build_req(make_va(0, 1, 0), PRIV_S, 1'b0, ACC_STORE, 11), XF_PERM, 2);
        xlat_one(build_req(make_va(0, 2, 0), PRIV_S, 1'b0, ACC_FETCH, 12), XF_PERM, 2);
        xlat_one(build_req(make_va(0, 0, 0), PRIV_U, 1'b0, ACC_LOAD, 13), XF_PRIV, 2);
        xlat_one(build_req(make_va(0, 3, 0), PRIV_S, 1'b0, ACC_LOAD, 14), XF_PRIV, 2);
        xlat_one(build_req(make_va(0, 3, 0), PRIV_S, 1'b1, ACC_LOAD, 15), XF_NONE, 2);
        // pointer found at level 0
        xlat_one(build_req(make_va(3, 1, 0), PRIV_S, 1'b0, ACC_LOAD, 0), XF_INVALID, 2);
    endtask

    task automatic test_concurrent();
        xlat_req_t    r;
        xlat_resp_t   exp [12];
        logic [31:0]  v1;
        logic [31:0]  v0;
        logic [31:0]  off;
        logic [31:0]  sel;
        access_kind_e acc;
        priv_e        pv;
        clear_seen();
        for (int t = 0; t < 12; t++) begin
            v1  = rand_bits(3);
            v0  = rand_bits(3);
            off = rand_bits(12);
            sel = rand_bits(2);
            acc = (sel == 2) ? ACC_FETCH : ((sel == 1) ? ACC_STORE : ACC_LOAD);
            pv  = (rand_bits(1) == 1) ? PRIV_U : PRIV_S;
            r   = build_req(make_va(v1, v0, off), pv, rand_bits(1) == 1, acc, t);
            exp[t] = ref_xlat(r);
            send(r);
        end
        while (resp_total < 12) begin
            @(posedge clk);
        end
        // late duplicates would show up here
        repeat (20) @(posedge clk);
        for (int t = 0; t < 12; t++) begin
            assert (got_cnt[t] == 1) else begin
                $display("FAIL response count (tag %h): got %h, expected 1", t, got_cnt[t]);
                abort_run();
            end
            check_resp(got[t], exp[t]);
        end
    endtask

    task automatic test_flush();
        clear_seen();
        send(build_req(make_va(0, 0, 'h010), PRIV_S, 1'b0, ACC_LOAD, 8));
        send(build_req(make_va(3, 0, 'h020), PRIV_U, 1'b0, ACC_STORE, 9));
        // hit a read that is still on the bus
        while (!mem_rd_en) begin
            @(posedge clk);
        end
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        xlat_one(build_req(make_va(3, 0, 'h030), PRIV_U, 1'b0, ACC_LOAD, 10), XF_NONE, 2);
        repeat (40) @(posedge clk);
        for (int t = 8; t <= 9; t++) begin
            assert (got_cnt[t] == 0) else begin
                $display("walk with tag %0d answered although it was flushed", t);
                abort_run();
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped answering", WATCHDOG);
        abort_run();
    end

    initial begin
        rst_n     = 1'b0;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        en_q      = 1'b0;
        rd_starts = 0;
        lfsr_q    = 16'd62692;
        clear_seen();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        build_tables();
        test_bare();
        test_walk_4k();
        test_superpage();
        test_faults();
        test_concurrent();
        test_flush();
        repeat (5) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sv32_mmu.f
+incdir+rtl
rtl/sv32_pkg.sv
rtl/walk_dispatch.sv
rtl/page_walker.sv
rtl/pte_read_arbiter.sv
rtl/result_collect.sv
rtl/sv32_mmu.sv
tests/pt_mem_model.sv
tests/tb_sv32_mmu.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_sv32_mmu
FILELIST  = sv32_mmu.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
